//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert --timing --timescale 1ns/1ps -j 0
TOP       := tb_dual_bus_loop
FILELIST  := list.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) src/loop_cfg.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- list.f
+incdir+src
src/loop_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/panel_master.sv
src/bus_fabric.sv
src/mem_slave.sv
src/uart_bridge_slave.sv
src/uart_bridge_master.sv
src/dual_bus_loop.sv
verif/tb_dual_bus_loop.sv

//--- src/bus_fabric.sv
`include "loop_cfg.svh"

module bus_fabric (
    input  logic               clk,
    input  logic               rstn,
    input  loop_pkg::bus_req_t host_req,
    output loop_pkg::bus_rsp_t host_rsp,
    output loop_pkg::bus_req_t local_req,
    input  loop_pkg::bus_rsp_t local_rsp,
    output loop_pkg::bus_req_t bridge_req,
    input  loop_pkg::bus_rsp_t bridge_rsp
);

    loop_pkg::tgt_t tgt;
    loop_pkg::tgt_t tgt_q;
    logic           none_done;

    // Address decode on the device number
    always_comb begin
        if (host_req.dev == `LOOP_DEV_W'(0)) begin
            tgt = loop_pkg::TGT_LOCAL;
        end else if (host_req.dev == `LOOP_DEV_W'(1)) begin
            tgt = loop_pkg::TGT_REMOTE;
        end else begin
            tgt = loop_pkg::TGT_NONE;
        end
    end

    always_comb begin
        local_req        = host_req;
        local_req.valid  = host_req.valid && (tgt == loop_pkg::TGT_LOCAL);
        bridge_req       = host_req;
        bridge_req.valid = host_req.valid && (tgt == loop_pkg::TGT_REMOTE);
    end

    // Target of the open transaction selects the response path
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tgt_q     <= loop_pkg::TGT_NONE;
            none_done <= 1'b0;
        end else begin
            none_done <= host_req.valid && (tgt == loop_pkg::TGT_NONE);
            if (host_req.valid) begin
                tgt_q <= tgt;
            end
        end
    end

    always_comb begin
        case (tgt_q)
            loop_pkg::TGT_LOCAL:  host_rsp = local_rsp;
            loop_pkg::TGT_REMOTE: host_rsp = bridge_rsp;
            default:              host_rsp = '{done: none_done, rdata: '0};
        endcase
    end

endmodule

//--- src/dual_bus_loop.sv
`include "loop_cfg.svh"

module dual_bus_loop (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  logic                     write_sw,
    input  logic [`LOOP_DEV_W-1:0]   dev_sw,
    input  logic [`LOOP_MEM_AW-1:0]  addr_sw,
    input  logic [`LOOP_DATA_W-1:0]  wdata_sw,
    output logic                     busy,
    output logic [`LOOP_DATA_W-1:0]  read_data,
    output logic [`LOOP_DATA_W-1:0]  led_local,
    output logic [`LOOP_DATA_W-1:0]  led_remote
);

    // ==============================
    // Bus A
    // ==============================
    loop_pkg::bus_req_t host_req;
    loop_pkg::bus_rsp_t host_rsp;
    loop_pkg::bus_req_t local_req;
    loop_pkg::bus_rsp_t local_rsp;
    loop_pkg::bus_req_t bridge_req;
    loop_pkg::bus_rsp_t bridge_rsp;

    // ==============================
    // UART link and bus B
    // ==============================
    logic               uart_a_to_b;
    logic               uart_b_to_a;
    loop_pkg::bus_req_t remote_req;
    loop_pkg::bus_rsp_t remote_rsp;

    panel_master u_panel (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .write_sw  (write_sw),
        .dev_sw    (dev_sw),
        .addr_sw   (addr_sw),
        .wdata_sw  (wdata_sw),
        .req       (host_req),
        .rsp       (host_rsp),
        .busy      (busy),
        .read_data (read_data)
    );

    bus_fabric u_fabric (
        .clk        (clk),
        .rstn       (rstn),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .local_req  (local_req),
        .local_rsp  (local_rsp),
        .bridge_req (bridge_req),
        .bridge_rsp (bridge_rsp)
    );

    mem_slave mem_local (
        .clk  (clk),
        .rstn (rstn),
        .req  (local_req),
        .rsp  (local_rsp),
        .led  (led_local)
    );

    uart_bridge_slave u_bridge_slave (
        .clk     (clk),
        .rstn    (rstn),
        .req     (bridge_req),
        .rsp     (bridge_rsp),
        .tx_line (uart_a_to_b),
        .rx_line (uart_b_to_a)
    );

    uart_bridge_master u_bridge_master (
        .clk     (clk),
        .rstn    (rstn),
        .rx_line (uart_a_to_b),
        .tx_line (uart_b_to_a),
        .req     (remote_req),
        .rsp     (remote_rsp)
    );

    mem_slave mem_remote (
        .clk  (clk),
        .rstn (rstn),
        .req  (remote_req),
        .rsp  (remote_rsp),
        .led  (led_remote)
    );

endmodule

//--- src/loop_cfg.svh
`ifndef LOOP_CFG_SVH
`define LOOP_CFG_SVH

// ==============================
// Bus geometry
// ==============================

// One data byte per access
`define LOOP_DATA_W 8

// 6 address bits give 64 bytes per memory
`define LOOP_MEM_AW 6

// Device number on bus A
`define LOOP_DEV_W 2

// ==============================
// UART timing
// ==============================

`define LOOP_CLKS_PER_BIT 5

`endif

//--- src/loop_pkg.sv
`include "loop_cfg.svh"

package loop_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_t;

    // Request strobe and payload, one per transaction
    typedef struct packed {
        logic                       valid;
        op_t                        op;
        logic [`LOOP_DEV_W-1:0]     dev;
        logic [`LOOP_MEM_AW-1:0]    addr;
        logic [`LOOP_DATA_W-1:0]    wdata;
    } bus_req_t;

    typedef struct packed {
        logic                       done;
        logic [`LOOP_DATA_W-1:0]    rdata;
    } bus_rsp_t;

    // Bus A targets
    typedef enum logic [1:0] {
        TGT_LOCAL,
        TGT_REMOTE,
        TGT_NONE
    } tgt_t;

    // Shared by both ends of the UART bridge
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_HDR,
        ST_SEND_DATA,
        ST_WAIT,
        ST_ACCESS,
        ST_REPLY
    } bridge_state_t;

endpackage

//--- src/mem_slave.sv
`include "loop_cfg.svh"

module mem_slave (
    input  logic                     clk,
    input  logic                     rstn,
    input  loop_pkg::bus_req_t       req,
    output loop_pkg::bus_rsp_t       rsp,
    output logic [`LOOP_DATA_W-1:0]  led
);

    logic [`LOOP_DATA_W-1:0] mem [0:(1 << `LOOP_MEM_AW) - 1];
    logic [`LOOP_DATA_W-1:0] rdata_q;
    logic                    done_q;

    // Storage and read port
    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.op == loop_pkg::OP_WRITE) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata_q <= mem[req.addr];
            end
        end
    end

    // Done one cycle after valid, LED shows the last write
    always_ff @(posedge clk) begin
        if (!rstn) begin
            done_q <= 1'b0;
            led    <= '0;
        end else begin
            done_q <= req.valid;
            if (req.valid && req.op == loop_pkg::OP_WRITE) begin
                led <= req.wdata;
            end
        end
    end

    assign rsp = '{done: done_q, rdata: rdata_q};

endmodule

//--- src/panel_master.sv
`include "loop_cfg.svh"

module panel_master (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  logic                     write_sw,
    input  logic [`LOOP_DEV_W-1:0]   dev_sw,
    input  logic [`LOOP_MEM_AW-1:0]  addr_sw,
    input  logic [`LOOP_DATA_W-1:0]  wdata_sw,
    output loop_pkg::bus_req_t       req,
    input  loop_pkg::bus_rsp_t       rsp,
    output logic                     busy,
    output logic [`LOOP_DATA_W-1:0]  read_data
);

    logic                     start_meta;
    logic                     start_sync;
    logic                     start_prev;
    logic                     launch;
    logic                     req_valid;
    loop_pkg::op_t            op_q;
    logic [`LOOP_DEV_W-1:0]   dev_q;
    logic [`LOOP_MEM_AW-1:0]  addr_q;
    logic [`LOOP_DATA_W-1:0]  wdata_q;

    // Rising edge of the synchronized button, ignored while busy
    assign launch = start_sync && !start_prev && !busy;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            start_meta <= 1'b0;
            start_sync <= 1'b0;
            start_prev <= 1'b0;
            req_valid  <= 1'b0;
            busy       <= 1'b0;
            read_data  <= '0;
        end else begin
            start_meta <= start;
            start_sync <= start_meta;
            start_prev <= start_sync;
            req_valid  <= launch;
            if (launch) begin
                busy <= 1'b1;
            end else if (rsp.done) begin
                busy <= 1'b0;
            end
            if (rsp.done && op_q == loop_pkg::OP_READ) begin
                read_data <= rsp.rdata;
            end
        end
    end

    // Switch snapshot stays put for the whole transaction
    always_ff @(posedge clk) begin
        if (launch) begin
            op_q    <= write_sw ? loop_pkg::OP_WRITE : loop_pkg::OP_READ;
            dev_q   <= dev_sw;
            addr_q  <= addr_sw;
            wdata_q <= wdata_sw;
        end
    end

    assign req = '{valid: req_valid, op: op_q, dev: dev_q, addr: addr_q, wdata: wdata_q};

endmodule

//--- src/uart_bridge_master.sv
`include "loop_cfg.svh"

module uart_bridge_master (
    input  logic               clk,
    input  logic               rstn,
    input  logic               rx_line,
    output logic               tx_line,
    output loop_pkg::bus_req_t req,
    input  loop_pkg::bus_rsp_t rsp
);

    loop_pkg::bridge_state_t state;
    logic [7:0]              rx_data;
    logic                    rx_strobe;
    logic [7:0]              tx_data;
    logic                    tx_send;
    logic                    tx_busy;
    logic [7:0]              hdr_q;
    logic [7:0]              wdata_q;
    logic                    req_valid;
    loop_pkg::op_t           op;

    assign op = loop_pkg::op_t'(hdr_q[`LOOP_DATA_W-1]);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= loop_pkg::ST_IDLE;
            req_valid <= 1'b0;
            tx_send   <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            tx_send   <= 1'b0;
            case (state)
                loop_pkg::ST_IDLE: begin
                    if (rx_strobe) begin
                        hdr_q <= rx_data;
                        state <= loop_pkg::ST_WAIT;
                    end
                end
                loop_pkg::ST_WAIT: begin
                    if (rx_strobe) begin
                        wdata_q   <= rx_data;
                        req_valid <= 1'b1;
                        state     <= loop_pkg::ST_ACCESS;
                    end
                end
                loop_pkg::ST_ACCESS: begin
                    if (rsp.done) begin
                        // Writes echo the byte that was written
                        tx_data <= (op == loop_pkg::OP_WRITE) ? wdata_q : rsp.rdata;
                        tx_send <= 1'b1;
                        state   <= loop_pkg::ST_REPLY;
                    end
                end
                default: begin
                    if (!tx_busy && !tx_send) begin
                        state <= loop_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Single target on bus B, device field unused
    assign req = '{valid: req_valid, op: op, dev: '0,
                   addr: hdr_q[`LOOP_MEM_AW-1:0], wdata: wdata_q};

    uart_rx #(.CLKS_PER_BIT(`LOOP_CLKS_PER_BIT)) u_rx (
        .clk    (clk),
        .rstn   (rstn),
        .line   (rx_line),
        .data   (rx_data),
        .strobe (rx_strobe)
    );

    uart_tx #(.CLKS_PER_BIT(`LOOP_CLKS_PER_BIT)) u_tx (
        .clk  (clk),
        .rstn (rstn),
        .data (tx_data),
        .send (tx_send),
        .busy (tx_busy),
        .line (tx_line)
    );

endmodule

//--- src/uart_bridge_slave.sv
`include "loop_cfg.svh"

module uart_bridge_slave (
    input  logic               clk,
    input  logic               rstn,
    input  loop_pkg::bus_req_t req,
    output loop_pkg::bus_rsp_t rsp,
    output logic               tx_line,
    input  logic               rx_line
);

    loop_pkg::bridge_state_t state;
    logic [7:0]              tx_data;
    logic                    tx_send;
    logic                    tx_busy;
    logic [7:0]              rx_data;
    logic                    rx_strobe;
    logic [7:0]              wdata_q;
    logic                    done_q;
    logic [7:0]              rdata_q;
    logic                    tx_free;

    // Send strobe is registered, so skip the cycle it is still visible
    assign tx_free = !tx_busy && !tx_send;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= loop_pkg::ST_IDLE;
            tx_send <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            tx_send <= 1'b0;
            done_q  <= 1'b0;
            case (state)
                loop_pkg::ST_IDLE: begin
                    if (req.valid) begin
                        // Header is op, a zero, then the address
                        tx_data <= {req.op, 1'b0, req.addr};
                        wdata_q <= req.wdata;
                        tx_send <= 1'b1;
                        state   <= loop_pkg::ST_SEND_HDR;
                    end
                end
                loop_pkg::ST_SEND_HDR: begin
                    if (tx_free) begin
                        tx_data <= wdata_q;
                        tx_send <= 1'b1;
                        state   <= loop_pkg::ST_SEND_DATA;
                    end
                end
                loop_pkg::ST_SEND_DATA: begin
                    if (tx_free) begin
                        state <= loop_pkg::ST_WAIT;
                    end
                end
                default: begin
                    if (rx_strobe) begin
                        rdata_q <= rx_data;
                        done_q  <= 1'b1;
                        state   <= loop_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    assign rsp = '{done: done_q, rdata: rdata_q};

    uart_tx #(.CLKS_PER_BIT(`LOOP_CLKS_PER_BIT)) u_tx (
        .clk  (clk),
        .rstn (rstn),
        .data (tx_data),
        .send (tx_send),
        .busy (tx_busy),
        .line (tx_line)
    );

    uart_rx #(.CLKS_PER_BIT(`LOOP_CLKS_PER_BIT)) u_rx (
        .clk    (clk),
        .rstn   (rstn),
        .line   (rx_line),
        .data   (rx_data),
        .strobe (rx_strobe)
    );

endmodule

//--- src/uart_rx.sv
module uart_rx #(
    parameter int CLKS_PER_BIT = 5
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       line,
    output logic [7:0] data,
    output logic       strobe
);

    localparam int CW   = $clog2(CLKS_PER_BIT);
    localparam int HALF = CLKS_PER_BIT / 2 - 1;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t     state;
    logic          line_meta;
    logic          line_s;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shreg;
    logic          bit_end;

    assign bit_end = (cnt == CW'(CLKS_PER_BIT - 1));
    // Shift register holds the byte until the next frame starts shifting
    assign data    = shreg;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            line_meta <= 1'b1;
            line_s    <= 1'b1;
            state     <= RX_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            strobe    <= 1'b0;
        end else begin
            line_meta <= line;
            line_s    <= line_meta;
            strobe    <= 1'b0;
            cnt       <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!line_s) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Middle of the start bit, a glitch returns to idle
                    if (cnt == CW'(HALF)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= line_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        shreg <= {line_s, shreg[7:1]};
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        strobe <= line_s;
                        state  <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- src/uart_tx.sv
module uart_tx #(
    parameter int CLKS_PER_BIT = 5
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic [7:0] data,
    input  logic       send,
    output logic       busy,
    output logic       line
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t   state;
    logic [CW-1:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shreg;
    logic        bit_end;

    assign bit_end = (cnt == CW'(CLKS_PER_BIT - 1));
    // Stays high through the stop bit
    assign busy    = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            line    <= 1'b1;
        end else begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (send) begin
                        shreg <= data;
                        line  <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        line    <= shreg[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            line  <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            // LSB first
                            shreg   <= shreg >> 1;
                            line    <= shreg[1];
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- verif/tb_dual_bus_loop.sv
`include "loop_cfg.svh"

module tb_dual_bus_loop;

    timeunit 1ns;
    timeprecision 1ps;

    // About 55 transactions, half of them remote at roughly 200 cycles each
    localparam int MAX_CYCLES = 20000;

    logic                     clk = 1'b0;
    logic                     rstn;
    logic                     start;
    logic                     write_sw;
    logic [`LOOP_DEV_W-1:0]   dev_sw;
    logic [`LOOP_MEM_AW-1:0]  addr_sw;
    logic [`LOOP_DATA_W-1:0]  wdata_sw;
    logic                     busy;
    logic [`LOOP_DATA_W-1:0]  read_data;
    logic [`LOOP_DATA_W-1:0]  led_local;
    logic [`LOOP_DATA_W-1:0]  led_remote;

    // ==============================
    // Reference model
    // ==============================
    logic [`LOOP_DATA_W-1:0]  ref_local  [0:(1 << `LOOP_MEM_AW) - 1];
    logic [`LOOP_DATA_W-1:0]  ref_remote [0:(1 << `LOOP_MEM_AW) - 1];
    logic [`LOOP_DATA_W-1:0]  exp_read;
    logic [`LOOP_DATA_W-1:0]  exp_led_local;
    logic [`LOOP_DATA_W-1:0]  exp_led_remote;
    logic                     hold_active;
    logic [`LOOP_DEV_W-1:0]   rnd_dev;
    logic [`LOOP_MEM_AW-1:0]  rnd_addr;
    logic [`LOOP_DATA_W-1:0]  rnd_data;
    logic [`LOOP_DEV_W-1:0]   dev_q  [$];
    logic [`LOOP_MEM_AW-1:0]  addr_q [$];
    int                       errors = 0;
    int                       cycle_count = 0;

    dual_bus_loop UUT (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .write_sw   (write_sw),
        .dev_sw     (dev_sw),
        .addr_sw    (addr_sw),
        .wdata_sw   (wdata_sw),
        .busy       (busy),
        .read_data  (read_data),
        .led_local  (led_local),
        .led_remote (led_remote)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a transaction never finished", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Start held high across switch changes must not launch anything
    hold_busy_low: assert property (@(posedge clk) disable iff (!rstn) hold_active |-> !busy)
        else begin
            $display("FAILED at %0t: busy expected 0, got %0b", $time, busy);
            errors = errors + 1;
        end

    hold_led_local: assert property (@(posedge clk) disable iff (!rstn)
        hold_active |-> led_local == exp_led_local)
        else begin
            $display("FAILED at %0t: led_local expected 0x%02h, got 0x%02h",
                     $time, exp_led_local, led_local);
            errors = errors + 1;
        end

    hold_led_remote: assert property (@(posedge clk) disable iff (!rstn)
        hold_active |-> led_remote == exp_led_remote)
        else begin
            $display("FAILED at %0t: led_remote expected 0x%02h, got 0x%02h",
                     $time, exp_led_remote, led_remote);
            errors = errors + 1;
        end

    task automatic check_value(input string name, input logic [`LOOP_DATA_W-1:0] expected,
                               input logic [`LOOP_DATA_W-1:0] actual);
        assert (actual === expected)
        else begin
            $display("FAILED at %0t: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic check_outputs();
        check_value("busy", 8'h00, `LOOP_DATA_W'(busy));
        check_value("read_data", exp_read, read_data);
        check_value("led_local", exp_led_local, led_local);
        check_value("led_remote", exp_led_remote, led_remote);
    endtask

    // Device 0 is local, 1 is remote, 2 and 3 read zero
    task automatic update_model(input logic wr, input logic [`LOOP_DEV_W-1:0] dev,
                                input logic [`LOOP_MEM_AW-1:0] addr,
                                input logic [`LOOP_DATA_W-1:0] data);
        if (dev == 2'd0) begin
            if (wr) begin
                ref_local[addr] = data;
                exp_led_local   = data;
            end else begin
                exp_read = ref_local[addr];
            end
        end else if (dev == 2'd1) begin
            if (wr) begin
                ref_remote[addr] = data;
                exp_led_remote   = data;
            end else begin
                exp_read = ref_remote[addr];
            end
        end else if (!wr) begin
            exp_read = '0;
        end
    endtask

    // Press start, wait for busy to rise and fall, then compare
    task automatic run_access(input logic wr, input logic [`LOOP_DEV_W-1:0] dev,
                              input logic [`LOOP_MEM_AW-1:0] addr,
                              input logic [`LOOP_DATA_W-1:0] data, input logic keep_start);
        repeat (3) @(posedge clk);
        write_sw <= wr;
        dev_sw   <= dev;
        addr_sw  <= addr;
        wdata_sw <= data;
        start    <= 1'b1;
        @(negedge clk);
        while (!busy) @(negedge clk);
        if (!keep_start) begin
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
        end
        while (busy) @(negedge clk);
        update_model(wr, dev, addr, data);
        check_outputs();
    endtask

    initial begin
        void'($urandom(69));
        rstn           = 1'b0;
        start          = 1'b0;
        write_sw       = 1'b0;
        dev_sw         = '0;
        addr_sw        = '0;
        wdata_sw       = '0;
        hold_active    = 1'b0;
        exp_read       = '0;
        exp_led_local  = '0;
        exp_led_remote = '0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_outputs();

        // ==============================
        // Directed local and remote
        // ==============================
        run_access(1'b1, 2'd0, 6'd3, 8'hA5, 1'b0);
        run_access(1'b0, 2'd0, 6'd3, 8'h00, 1'b0);
        run_access(1'b1, 2'd1, 6'd3, 8'h3C, 1'b0);
        run_access(1'b0, 2'd1, 6'd3, 8'h00, 1'b0);
        run_access(1'b0, 2'd0, 6'd3, 8'h00, 1'b0);
        // Same address in both memories
        run_access(1'b1, 2'd0, 6'd17, 8'h11, 1'b0);
        run_access(1'b1, 2'd1, 6'd17, 8'h22, 1'b0);
        run_access(1'b0, 2'd0, 6'd17, 8'h00, 1'b0);
        run_access(1'b0, 2'd1, 6'd17, 8'h00, 1'b0);

        // ==============================
        // Random writes, then read back
        // ==============================
        for (int i = 0; i < 20; i++) begin
            rnd_dev  = `LOOP_DEV_W'($urandom_range(0, 1));
            rnd_addr = `LOOP_MEM_AW'($urandom);
            rnd_data = `LOOP_DATA_W'($urandom);
            run_access(1'b1, rnd_dev, rnd_addr, rnd_data, 1'b0);
            dev_q.push_back(rnd_dev);
            addr_q.push_back(rnd_addr);
        end
        foreach (addr_q[i]) begin
            run_access(1'b0, dev_q[i], addr_q[i], 8'h00, 1'b0);
        end

        // Unmapped devices (TGT_NONE)
        run_access(1'b1, 2'd2, 6'd3, 8'hFF, 1'b0);
        run_access(1'b0, 2'd3, 6'd3, 8'h00, 1'b0);
        run_access(1'b0, 2'd2, 6'd17, 8'h00, 1'b0);

        // ==============================
        // Start held high
        // ==============================
        run_access(1'b1, 2'd0, 6'd9, 8'h5A, 1'b1);
        // New local byte first, then a remote write long enough to land
        @(posedge clk);
        write_sw    <= 1'b1;
        wdata_sw    <= 8'h96;
        hold_active <= 1'b1;
        repeat (20) @(posedge clk);
        dev_sw      <= 2'd1;
        wdata_sw    <= 8'hC3;
        repeat (200) @(posedge clk);
        hold_active <= 1'b0;
        start       <= 1'b0;
        @(negedge clk);
        check_outputs();
        run_access(1'b1, 2'd1, 6'd9, 8'hC3, 1'b0);
        run_access(1'b0, 2'd0, 6'd9, 8'h00, 1'b0);

        repeat (5) @(posedge clk);
        $display("Run finished with %0d errors in %0d cycles", errors, cycle_count);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
